// ==== common/pad_beat_if.sv ====
// Beat-level links between the padder stages.
// pad_ctrl_if carries the control decisions, pad_beat_if the block writes.

`default_nettype none

interface pad_ctrl_if import sha3_pad_pkg::*; ();
  beat_sel_e           beat_sel;
  logic [MsgAddrW-1:0] beat_addr;
  logic                end_of_block;
  logic                beat_wr;
  logic                clr_block;
  // Partial last word capture, with its byte count
  logic                buf_load;
  logic [2:0]          buf_bytes;
  logic                buf_clr;

  modport ctrl (output beat_sel, beat_addr, end_of_block, beat_wr, clr_block,
                output buf_load, buf_bytes, buf_clr);
  modport former (input beat_sel, beat_addr, end_of_block, beat_wr, clr_block,
                  input buf_load, buf_bytes, buf_clr);
endinterface

interface pad_beat_if import sha3_pad_pkg::*; ();
  logic                wr_en;
  logic [MsgAddrW-1:0] wr_addr;
  logic [MsgWidth-1:0] wr_data;
  logic                clr;

  modport src (output wr_en, wr_addr, wr_data, clr);
  modport sink (input wr_en, wr_addr, wr_data, clr);
endinterface

`default_nettype wire

// ==== common/sha3_pad_pkg.sv ====
// Shared widths, enums and pad constants for the Keccak sponge input padder.
// The control, beat-forming and block stages import it whole.

`default_nettype none

package sha3_pad_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int KeccakWidth = 1600;
  localparam int MsgWidth    = 64;
  localparam int MsgStrbW    = MsgWidth / 8;
  localparam int MsgEntries  = KeccakWidth / MsgWidth;
  localparam int MsgAddrW    = $clog2(MsgEntries);

  // encode_string(N) || encode_string(S), prepared by software
  localparam int NsBytes     = 62;
  // Two bytepad header bytes in front of N||S
  localparam int PrefixBytes = NsBytes + 2;
  localparam int PrefixWords = PrefixBytes / MsgStrbW;
  localparam int PrefixIdxW  = $clog2(PrefixWords);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    Sha3   = 2'd0,
    Shake  = 2'd1,
    CShake = 2'd2
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  typedef enum logic [2:0] {
    StIdle       = 3'd0,
    StPrefix     = 3'd1,
    StPrefixWait = 3'd2,
    StMessage    = 3'd3,
    StPad        = 3'd4,
    StPadRun     = 3'd5,
    StPad01      = 3'd6,
    StPadFlush   = 3'd7
  } pad_st_e;

  // Source of the beat written into the block register
  typedef enum logic [2:0] {
    BeatNone    = 3'd0,
    BeatFifo    = 3'd1,
    BeatPrefix  = 3'd2,
    BeatFuncPad = 3'd3,
    BeatZeroEnd = 3'd4
  } beat_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Constant functions
  //////////////////////////////////////////////////////////////////////

  // Rate in 64-bit words
  function automatic logic [MsgAddrW-1:0] rate_words(keccak_strength_e strength);
    logic [MsgAddrW-1:0] words;
    unique case (strength)
      L128:    words = MsgAddrW'(21);
      L224:    words = MsgAddrW'(18);
      L256:    words = MsgAddrW'(17);
      L384:    words = MsgAddrW'(13);
      L512:    words = MsgAddrW'(9);
      // Undefined codes fall back to the smallest rate
      default: words = MsgAddrW'(9);
    endcase
    return words;
  endfunction

  // left_encode(rate in bytes), first byte in the low bits
  function automatic logic [15:0] bytepad_header(keccak_strength_e strength);
    logic [7:0] rate_bytes;
    rate_bytes = {rate_words(strength), 3'b000};
    return {rate_bytes, 8'h01};
  endfunction

  // Domain bits plus the first 1 of pad10*1, from the first free bit up
  function automatic logic [4:0] func_pad(sha3_mode_e mode);
    logic [4:0] bits;
    unique case (mode)
      Sha3:    bits = 5'b00110;
      Shake:   bits = 5'b11111;
      CShake:  bits = 5'b00100;
      default: bits = 5'b00001;
    endcase
    return bits;
  endfunction

endpackage

`default_nettype wire

// ==== pad_ctrl/pad_ctrl_fsm.sv ====
// Padding sequencer of the input padder.
// Walks prefix (cSHAKE only), message, function pad and zero-end beats,
// counts beats against the rate and starts the Keccak round per full block.

`default_nettype none

module pad_ctrl_fsm
  import sha3_pad_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 rst_b,
  input  wire logic                 msg_valid_i,
  input  wire logic [MsgStrbW-1:0]  msg_strb_i,
  input  wire logic                 keccak_ready_i,
  input  wire logic                 keccak_complete_i,
  input  var  sha3_mode_e           mode_i,
  input  var  keccak_strength_e     strength_i,
  input  wire logic                 start_i,
  input  wire logic                 process_i,
  output logic                      msg_ready_o,
  output logic                      keccak_run_o,
  output logic                      absorbed_o,
  pad_ctrl_if.ctrl                  ctrl_o
);

  pad_st_e             st_q, st_d;
  logic [MsgAddrW-1:0] cnt_q;
  logic [MsgAddrW-1:0] rate;
  logic                end_of_block;
  logic                block_full;
  logic                process_q;
  logic                process_seen;
  logic                msg_full;
  logic [2:0]          strb_bytes;
  beat_sel_e           beat_sel;
  logic                beat_wr;
  logic                clr_block;
  logic                buf_load;
  logic                buf_clr;
  logic                absorbed_d;

  //////////////////////////////////////////////////////////////////////
  // Beat counter and status
  //////////////////////////////////////////////////////////////////////

  assign rate         = rate_words(strength_i);
  // Current beat is the last word of the rate
  assign end_of_block = (cnt_q + MsgAddrW'(1)) == rate;
  // All rate words written and the block waits for the Keccak round
  assign block_full   = cnt_q == rate;

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      cnt_q <= '0;
    end else if (clr_block) begin
      cnt_q <= '0;
    end else if (beat_wr) begin
      cnt_q <= cnt_q + MsgAddrW'(1);
    end
  end

  // Only full words go to the block and anything else is the last word
  assign msg_full = &msg_strb_i;

  // Partial strobes are contiguous from byte 0
  always_comb begin
    strb_bytes = '0;
    for (int i = 0; i < MsgStrbW - 1; i++) begin
      if (msg_strb_i[i]) begin
        strb_bytes = strb_bytes + 3'd1;
      end
    end
  end

  // Remember process until the next start
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      process_q <= 1'b0;
    end else if (process_i) begin
      process_q <= 1'b1;
    end else if (start_i) begin
      process_q <= 1'b0;
    end
  end

  assign process_seen = process_q | process_i;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      st_q       <= StIdle;
      absorbed_o <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_o <= absorbed_d;
    end
  end

  always_comb begin
    st_d         = st_q;
    beat_sel     = BeatNone;
    beat_wr      = 1'b0;
    clr_block    = 1'b0;
    buf_load     = 1'b0;
    buf_clr      = 1'b0;
    msg_ready_o  = 1'b0;
    keccak_run_o = 1'b0;
    absorbed_d   = 1'b0;

    unique case (st_q)
      StIdle: begin
        if (start_i) begin
          st_d = (mode_i == CShake) ? StPrefix : StMessage;
        end
      end

      // bytepad(N||S) block zero-filled up to the rate
      StPrefix: begin
        beat_sel = BeatPrefix;
        if (!block_full) begin
          beat_wr = 1'b1;
        end else if (keccak_ready_i) begin
          keccak_run_o = 1'b1;
          clr_block    = 1'b1;
          st_d         = StPrefixWait;
        end
      end

      // Message must land on top of the absorbed prefix
      StPrefixWait: begin
        if (keccak_complete_i) begin
          st_d = StMessage;
        end
      end

      StMessage: begin
        beat_sel = BeatFifo;
        if (block_full) begin
          // Port stays closed until the round takes the block
          if (keccak_ready_i) begin
            keccak_run_o = 1'b1;
            clr_block    = 1'b1;
          end
        end else if (msg_valid_i) begin
          msg_ready_o = 1'b1;
          beat_wr     = msg_full;
          buf_load    = !msg_full;
        end else if (process_seen) begin
          st_d = StPad;
        end
      end

      // Held-back bytes merged with function pad and the end bit if last word
      StPad: begin
        beat_sel = BeatFuncPad;
        beat_wr  = 1'b1;
        buf_clr  = 1'b1;
        st_d     = end_of_block ? StPadRun : StPad01;
      end

      StPadRun: begin
        if (keccak_ready_i) begin
          keccak_run_o = 1'b1;
          clr_block    = 1'b1;
          st_d         = StPadFlush;
        end
      end

      // Zero words where the last one carries the pad10*1 end bit
      StPad01: begin
        beat_sel = BeatZeroEnd;
        if (!block_full) begin
          beat_wr = 1'b1;
        end else if (keccak_ready_i) begin
          keccak_run_o = 1'b1;
          clr_block    = 1'b1;
          st_d         = StPadFlush;
        end
      end

      StPadFlush: begin
        if (keccak_complete_i) begin
          absorbed_d = 1'b1;
          st_d       = StIdle;
        end
      end

      default: st_d = StIdle;
    endcase
  end

  assign ctrl_o.beat_sel     = beat_sel;
  assign ctrl_o.beat_addr    = cnt_q;
  assign ctrl_o.end_of_block = end_of_block;
  assign ctrl_o.beat_wr      = beat_wr;
  assign ctrl_o.clr_block    = clr_block;
  assign ctrl_o.buf_load     = buf_load;
  assign ctrl_o.buf_bytes    = strb_bytes;
  assign ctrl_o.buf_clr      = buf_clr;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  run_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    keccak_run_o |=> !keccak_run_o);

  absorbed_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    absorbed_o |=> !absorbed_o);

  // Zero-end words only follow a pad word that left room in the block
  pad01_not_at_end_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    (st_q == StPad01 && $past(st_q) == StPad) |-> !block_full);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the padder testbench with Verilator, run it and search the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_sha3_pad \
  && ./obj_dir/Vtb_sha3_pad > sim.log 2>&1 \
  || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -q "^Result: PASSED$" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sources.f ====
+incdir+tests
common/sha3_pad_pkg.sv
common/pad_beat_if.sv
pad_ctrl/pad_ctrl_fsm.sv
verilog/pad_beat_former.sv
verilog/block_assembler.sv
verilog/sha3_pad_top.sv
tests/tb_sha3_pad.sv

// ==== tests/sha3_pad_model.svh ====
// Reference model of the sponge padder, included into the testbench module.
// Builds the padded byte stream of one run and cuts it into expected blocks.

`ifndef SHA3_PAD_MODEL_SVH
`define SHA3_PAD_MODEL_SVH

// Full message words of the current run, oldest first
logic [MsgWidth-1:0]    msg_words[$];
// Expected blocks, popped by the compare process on each run
logic [KeccakWidth-1:0] exp_blocks[$];

// Block size in bytes per security level
function automatic int model_rate_bytes(keccak_strength_e strength);
  int bytes;
  case (strength)
    L128:    bytes = 168;
    L224:    bytes = 144;
    L256:    bytes = 136;
    L384:    bytes = 104;
    L512:    bytes = 72;
    default: bytes = 72;
  endcase
  return bytes;
endfunction

// Domain bits plus the first pad bit, as one byte
function automatic logic [7:0] model_pad_byte(sha3_mode_e mode);
  logic [7:0] pad;
  case (mode)
    Sha3:    pad = 8'h06;
    Shake:   pad = 8'h1f;
    CShake:  pad = 8'h04;
    default: pad = 8'h01;
  endcase
  return pad;
endfunction

// Appends the expected blocks of one run to exp_blocks
function automatic void build_expected(sha3_mode_e mode, keccak_strength_e strength,
                                       logic [NsBytes*8-1:0] ns,
                                       logic [MsgWidth-1:0] part_word, int part_bytes);
  logic [7:0]             stream[$];
  logic [KeccakWidth-1:0] blk;
  int                     rate;
  int                     pos;
  rate = model_rate_bytes(strength);

  // bytepad(N||S) as a block of its own
  if (mode == CShake) begin
    stream.push_back(8'h01);
    stream.push_back(8'(rate));
    for (int i = 0; i < NsBytes; i++) begin
      stream.push_back(ns[i*8 +: 8]);
    end
    while (stream.size() % rate != 0) begin
      stream.push_back(8'h00);
    end
  end

  // Message bytes, byte 0 of a word first
  foreach (msg_words[w]) begin
    for (int b = 0; b < MsgStrbW; b++) begin
      stream.push_back(msg_words[w][b*8 +: 8]);
    end
  end
  for (int b = 0; b < part_bytes; b++) begin
    stream.push_back(part_word[b*8 +: 8]);
  end

  // pad10*1, end bit in the last byte of the block
  stream.push_back(model_pad_byte(mode));
  while (stream.size() % rate != 0) begin
    stream.push_back(8'h00);
  end
  stream[stream.size()-1] = stream[stream.size()-1] | 8'h80;

  // Capacity part of each block stays zero
  pos = 0;
  while (pos < stream.size()) begin
    blk = '0;
    for (int i = 0; i < rate; i++) begin
      blk[i*8 +: 8] = stream[pos + i];
    end
    exp_blocks.push_back(blk);
    pos = pos + rate;
  end
endfunction

`endif

// ==== tests/tb_sha3_pad.sv ====
// Testbench for the Keccak sponge input padder.
// Drives SHA3, SHAKE and cSHAKE runs, answers each Keccak run after a fixed
// delay and compares every block handed over against the byte-stream model.

`default_nettype none

module tb_sha3_pad
  import sha3_pad_pkg::*;
();

  localparam int ClkPeriod      = 40;
  localparam int Quarter        = ClkPeriod / 4;
  localparam int KeccakDelay    = 24;
  localparam int WordLimit      = 200;
  // Message words and runs over all tests
  localparam int TotalWords     = 111;
  localparam int TotalRuns      = 12;
  localparam int WatchdogCycles = (TotalWords / 9 + 2 * TotalRuns) * 40 + 1000;

  logic                   clk_i;
  logic                   rst_b;
  logic                   msg_valid_i;
  logic [MsgWidth-1:0]    msg_data_i;
  logic [MsgStrbW-1:0]    msg_strb_i;
  logic                   msg_ready_o;
  logic [NsBytes*8-1:0]   ns_data_i;
  logic [KeccakWidth-1:0] keccak_data_o;
  logic                   keccak_ready_i;
  logic                   keccak_run_o;
  logic                   keccak_complete_i;
  sha3_mode_e             mode_i;
  keccak_strength_e       strength_i;
  logic                   start_i;
  logic                   process_i;
  logic                   absorbed_o;

  int          error_count    = 0;
  int          run_count      = 0;
  int          absorbed_count = 0;
  int          stall_count    = 0;
  int          words_in_block = 0;
  int          cur_rate_words = 17;
  logic [31:0] lcg_state;

  `include "sha3_pad_model.svh"

  sha3_pad_top u_sha3_pad_top (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .msg_valid_i       (msg_valid_i),
    .msg_data_i        (msg_data_i),
    .msg_strb_i        (msg_strb_i),
    .msg_ready_o       (msg_ready_o),
    .ns_data_i         (ns_data_i),
    .keccak_data_o     (keccak_data_o),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_run_o      (keccak_run_o),
    .keccak_complete_i (keccak_complete_i),
    .mode_i            (mode_i),
    .strength_i        (strength_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .absorbed_o        (absorbed_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Keccak responder and compare process
  //////////////////////////////////////////////////////////////////////

  // Round stays busy from each run until complete KeccakDelay cycles later
  initial begin : keccak_responder
    keccak_ready_i    = 1'b1;
    keccak_complete_i = 1'b0;
    @(negedge clk_i);
    forever begin
      #(Quarter);
      if (rst_b && keccak_run_o) begin
        @(negedge clk_i);
        keccak_ready_i = 1'b0;
        repeat (KeccakDelay - 1) @(negedge clk_i);
        keccak_complete_i = 1'b1;
        @(negedge clk_i);
        keccak_complete_i = 1'b0;
        keccak_ready_i    = 1'b1;
      end else begin
        @(negedge clk_i);
      end
    end
  end

  // Samples a quarter period before each rising edge when all outputs are settled
  initial begin : compare_blocks
    logic [KeccakWidth-1:0] snap;
    logic [KeccakWidth-1:0] exp_blk;
    forever begin
      @(negedge clk_i);
      #(Quarter);
      if (rst_b) begin
        // Port must stay closed while a full block waits
        if (words_in_block == cur_rate_words && msg_ready_o) begin
          error_count++;
          $display("Message port open while a full block waits for the Keccak round");
        end
        if (words_in_block == cur_rate_words && msg_valid_i && !keccak_run_o) begin
          stall_count++;
        end
        if (msg_valid_i && msg_ready_o && msg_strb_i == 8'hff) begin
          words_in_block++;
        end
        if (absorbed_o) begin
          absorbed_count++;
        end
        if (keccak_run_o) begin
          run_count++;
          words_in_block = 0;
          snap = keccak_data_o;
          if (!keccak_ready_i) begin
            error_count++;
            $display("Keccak run started while the round was busy");
          end
          if (exp_blocks.size() == 0) begin
            error_count++;
            $display("Keccak run with no expected block left");
          end else begin
            exp_blk = exp_blocks.pop_front();
            // Words above the rate are zero in the model
            for (int w = 0; w < MsgEntries; w++) begin
              if (snap[w*MsgWidth +: MsgWidth] !== exp_blk[w*MsgWidth +: MsgWidth]) begin
                error_count++;
                $display("FAIL keccak_data_o word %0d: expected %h, got %h", w,
                         exp_blk[w*MsgWidth +: MsgWidth], snap[w*MsgWidth +: MsgWidth]);
              end
            end
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // Holds one word on the port from a falling edge until it is taken
  task automatic send_word(input logic [MsgWidth-1:0] data, input logic [MsgStrbW-1:0] strb);
    bit accepted;
    int waited;
    accepted    = 1'b0;
    waited      = 0;
    msg_valid_i = 1'b1;
    msg_data_i  = data;
    msg_strb_i  = strb;
    while (!accepted && waited < WordLimit) begin
      #(Quarter);
      accepted = msg_ready_o;
      waited++;
      @(negedge clk_i);
    end
    if (!accepted) begin
      error_count++;
      $display("Message word not accepted within %0d cycles", WordLimit);
    end
  endtask

  // One hash run from start to absorbed
  task automatic run_hash(input sha3_mode_e mode, input keccak_strength_e strength,
                          input int n_words, input bit send_part, input int part_bytes,
                          input bit expect_stall);
    logic [MsgWidth-1:0] part_word;
    int                  exp_runs;
    int                  runs_before;
    int                  absorbed_before;
    int                  stalls_before;
    int                  waited;
    msg_words.delete();
    for (int i = 0; i < n_words; i++) begin
      msg_words.push_back({lcg_next(), lcg_next()});
    end
    // Bytes above k are random and must be masked
    part_word = {lcg_next(), lcg_next()};
    build_expected(mode, strength, ns_data_i, part_word, part_bytes);
    exp_runs        = exp_blocks.size();
    runs_before     = run_count;
    absorbed_before = absorbed_count;
    stalls_before   = stall_count;
    cur_rate_words  = model_rate_bytes(strength) / MsgStrbW;
    words_in_block  = 0;

    mode_i     = mode;
    strength_i = strength;
    start_i    = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    foreach (msg_words[i]) begin
      send_word(msg_words[i], '1);
    end
    if (send_part) begin
      send_word(part_word, MsgStrbW'((1 << part_bytes) - 1));
    end
    msg_valid_i = 1'b0;
    process_i   = 1'b1;
    @(negedge clk_i);
    process_i = 1'b0;

    waited = 0;
    while (absorbed_count == absorbed_before && waited < 400) begin
      @(negedge clk_i);
      waited++;
    end
    if (absorbed_count == absorbed_before) begin
      error_count++;
      $display("No absorbed pulse within 400 cycles of process");
    end
    // Room for a stray second pulse
    repeat (4) @(negedge clk_i);
    if (absorbed_count - absorbed_before != 1) begin
      error_count++;
      $display("FAIL absorbed_o pulses: expected %h, got %h", 1, absorbed_count - absorbed_before);
    end
    if (run_count - runs_before != exp_runs) begin
      error_count++;
      $display("FAIL keccak_run_o pulses: expected %h, got %h", exp_runs, run_count - runs_before);
    end
    if (expect_stall && stall_count == stalls_before) begin
      error_count++;
      $display("No back-pressure seen although a full block had to wait");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    logic [31:0] r;
    rst_b             = 1'b0;
    msg_valid_i       = 1'b0;
    msg_data_i        = '0;
    msg_strb_i        = '0;
    ns_data_i         = '0;
    mode_i            = Sha3;
    strength_i        = L256;
    start_i           = 1'b0;
    process_i         = 1'b0;
    lcg_state         = 32'd65;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_b = 1'b1;

    // Valid alone must not open the port while idle after reset
    msg_valid_i = 1'b1;
    #(Quarter);
    if (msg_ready_o !== 1'b0) begin
      error_count++;
      $display("FAIL msg_ready_o: expected %h, got %h", 1'b0, msg_ready_o);
    end
    if (keccak_run_o !== 1'b0) begin
      error_count++;
      $display("FAIL keccak_run_o: expected %h, got %h", 1'b0, keccak_run_o);
    end
    if (absorbed_o !== 1'b0) begin
      error_count++;
      $display("FAIL absorbed_o: expected %h, got %h", 1'b0, absorbed_o);
    end
    if (keccak_data_o !== '0) begin
      error_count++;
      $display("FAIL keccak_data_o: expected %h, got %h", '0, keccak_data_o);
    end
    @(negedge clk_i);
    msg_valid_i = 1'b0;
    @(negedge clk_i);

    // SHA3-256 over three blocks where the second block stalls on the round
    run_hash(Sha3, L256, 40, 1'b0, 0, 1'b1);
    // SHAKE128 with a partial last word of every length
    for (int k = 0; k < MsgStrbW; k++) begin
      run_hash(Shake, L128, 5, 1'b1, k, 1'b0);
    end
    // cSHAKE256 with random N||S
    for (int i = 0; i < NsBytes; i++) begin
      r = lcg_next();
      ns_data_i[i*8 +: 8] = r[15:8];
    end
    run_hash(CShake, L256, 6, 1'b0, 0, 1'b0);
    // SHA3-512 with the pad word last in the block and then a pad-only block
    run_hash(Sha3, L512, 8, 1'b0, 0, 1'b0);
    run_hash(Sha3, L512, 9, 1'b0, 0, 1'b0);

    $display("Blocks checked: %0d, absorbed pulses: %0d, errors: %0d",
             run_count, absorbed_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/block_assembler.sv ====
// 25-word block register in front of the Keccak round.
// One beat is stored per cycle; a clear empties the block after each run.

`default_nettype none

module block_assembler
  import sha3_pad_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_b,
  pad_beat_if.sink               beat_i,
  output logic [KeccakWidth-1:0] keccak_data_o
);

  logic [MsgEntries-1:0][MsgWidth-1:0] block_q;

  // Words above the rate stay zero, Keccak sees a clean capacity
  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      block_q <= '0;
    end else if (beat_i.clr) begin
      block_q <= '0;
    end else if (beat_i.wr_en) begin
      block_q[beat_i.wr_addr] <= beat_i.wr_data;
    end
  end

  // Word 0 in the low bits, lane order of the Keccak state
  assign keccak_data_o = block_q;

  // Beat counter in the control stage never runs past the state
  wr_addr_range_a: assert property (@(posedge clk_i) disable iff (!rst_b)
    beat_i.wr_en |-> beat_i.wr_addr < MsgAddrW'(MsgEntries));

endmodule

`default_nettype wire

// ==== verilog/pad_beat_former.sv ====
// Middle stage of the padder, combinational apart from the partial word buffer.
// Picks message, prefix, function pad or zero-end data for the current beat.

`default_nettype none

module pad_beat_former
  import sha3_pad_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_b,
  input  wire logic [MsgWidth-1:0]   msg_data_i,
  input  wire logic [NsBytes*8-1:0]  ns_data_i,
  input  var  keccak_strength_e      strength_i,
  input  var  sha3_mode_e            mode_i,
  pad_ctrl_if.former                 ctrl_i,
  pad_beat_if.src                    beat_o
);

  logic [MsgWidth-9:0]      buf_data_q;
  logic [2:0]               buf_bytes_q;
  logic [PrefixBytes*8-1:0] prefix;
  logic [PrefixIdxW-1:0]    prefix_idx;
  logic [MsgWidth-1:0]      prefix_word;
  logic [MsgWidth-1:0]      byte_mask;
  logic [MsgWidth-1:0]      pad_word;
  logic [MsgWidth-1:0]      zero_end_word;
  logic [MsgWidth-1:0]      beat_data;

  //////////////////////////////////////////////////////////////////////
  // Partial last word
  //////////////////////////////////////////////////////////////////////

  // Top byte is never valid in a partial word, 56 bits suffice
  always_ff @(posedge clk_i) begin
    if (ctrl_i.buf_load) begin
      buf_data_q <= msg_data_i[MsgWidth-9:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_b) begin
    if (!rst_b) begin
      buf_bytes_q <= '0;
    end else if (ctrl_i.buf_load) begin
      buf_bytes_q <= ctrl_i.buf_bytes;
    end else if (ctrl_i.buf_clr) begin
      buf_bytes_q <= '0;
    end
  end

  // Keep only the k bytes that were strobed
  always_comb begin
    byte_mask = '0;
    for (int i = 0; i < MsgStrbW - 1; i++) begin
      if (i < int'(buf_bytes_q)) begin
        byte_mask[i*8 +: 8] = 8'hff;
      end
    end
  end

  // Bytes, then domain bits at byte k, then the optional end bit
  assign pad_word = {ctrl_i.end_of_block, {(MsgWidth-1){1'b0}}}
                  | (MsgWidth'(func_pad(mode_i)) << {buf_bytes_q, 3'b000})
                  | ({8'h00, buf_data_q} & byte_mask);

  assign zero_end_word = {ctrl_i.end_of_block, {(MsgWidth-1){1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // Prefix slice
  //////////////////////////////////////////////////////////////////////

  // bytepad header occupies the two lowest bytes of word 0
  assign prefix     = {ns_data_i, bytepad_header(strength_i)};
  assign prefix_idx = ctrl_i.beat_addr[PrefixIdxW-1:0];
  // Zero fill past the prefix up to the rate
  assign prefix_word = (ctrl_i.beat_addr < MsgAddrW'(PrefixWords))
                     ? prefix[prefix_idx*MsgWidth +: MsgWidth] : '0;

  //////////////////////////////////////////////////////////////////////
  // Beat mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl_i.beat_sel)
      BeatFifo:    beat_data = msg_data_i;
      BeatPrefix:  beat_data = prefix_word;
      BeatFuncPad: beat_data = pad_word;
      BeatZeroEnd: beat_data = zero_end_word;
      default:     beat_data = '0;
    endcase
  end

  assign beat_o.wr_en   = ctrl_i.beat_wr;
  assign beat_o.wr_addr = ctrl_i.beat_addr;
  assign beat_o.wr_data = beat_data;
  assign beat_o.clr     = ctrl_i.clr_block;

endmodule

`default_nettype wire

// ==== verilog/sha3_pad_top.sv ====
// Keccak sponge input padder for SHA3, SHAKE and cSHAKE.
// Takes 64-bit message words, emits full 1600-bit blocks with a run pulse
// to an external Keccak round and reports absorbed once the pad block is done.

`default_nettype none

module sha3_pad_top
  import sha3_pad_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_b,

  // Message port
  input  wire logic                   msg_valid_i,
  input  wire logic [MsgWidth-1:0]    msg_data_i,
  input  wire logic [MsgStrbW-1:0]    msg_strb_i,
  output logic                        msg_ready_o,

  // N||S string for cSHAKE
  input  wire logic [NsBytes*8-1:0]   ns_data_i,

  // Keccak round side
  output logic [KeccakWidth-1:0]      keccak_data_o,
  input  wire logic                   keccak_ready_i,
  output logic                        keccak_run_o,
  input  wire logic                   keccak_complete_i,

  // Configuration and control
  input  var  sha3_mode_e             mode_i,
  input  var  keccak_strength_e       strength_i,
  input  wire logic                   start_i,
  input  wire logic                   process_i,
  output logic                        absorbed_o
);

  pad_ctrl_if u_ctrl_if ();
  pad_beat_if u_beat_if ();

  // Control stage, registers state and beat counter
  pad_ctrl_fsm u_pad_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_b             (rst_b),
    .msg_valid_i       (msg_valid_i),
    .msg_strb_i        (msg_strb_i),
    .keccak_ready_i    (keccak_ready_i),
    .keccak_complete_i (keccak_complete_i),
    .mode_i            (mode_i),
    .strength_i        (strength_i),
    .start_i           (start_i),
    .process_i         (process_i),
    .msg_ready_o       (msg_ready_o),
    .keccak_run_o      (keccak_run_o),
    .absorbed_o        (absorbed_o),
    .ctrl_o            (u_ctrl_if.ctrl)
  );

  // Combinational beat selection, plus the partial word buffer
  pad_beat_former u_pad_beat_former (
    .clk_i      (clk_i),
    .rst_b      (rst_b),
    .msg_data_i (msg_data_i),
    .ns_data_i  (ns_data_i),
    .strength_i (strength_i),
    .mode_i     (mode_i),
    .ctrl_i     (u_ctrl_if.former),
    .beat_o     (u_beat_if.src)
  );

  // Block register seen by the Keccak round
  block_assembler u_block_assembler (
    .clk_i         (clk_i),
    .rst_b         (rst_b),
    .beat_i        (u_beat_if.sink),
    .keccak_data_o (keccak_data_o)
  );

endmodule

`default_nettype wire
